//--- hw/axi_wr_arb_pkg.sv
package axi_wr_arb_pkg;

    ////////////////////
    // Widths and counts
    ////////////////////

    localparam int NUM_MASTERS = 3;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;  // One strobe bit per byte lane
    localparam int PROT_W = 3;

    // Longest grant without a B handshake
    localparam int QUANTUM_CYCLES = 16;
    localparam int QCNT_W = $clog2(QUANTUM_CYCLES + 1);  // Must hold QUANTUM_CYCLES itself

    ////////////////////
    // Types
    ////////////////////

    // Valid/ready vectors and the one-hot grant
    typedef logic [NUM_MASTERS-1:0] master_vec_t;

    // Write address channel payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [PROT_W-1:0] prot;
    } aw_payload_t;

    // Write data channel payload
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_payload_t;

endpackage

//--- hw/onehot_payload_mux.sv
`timescale 1ns/1ns

module onehot_payload_mux #(
    parameter type payload_t = logic [31:0]
) (
    input  axi_wr_arb_pkg::master_vec_t                                i_sel,
    input  payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0]                 i_payload,
    output payload_t                                                   o_payload
);

    import axi_wr_arb_pkg::*;

    // AND-OR select, all zeros when nothing is granted
    always_comb begin
        o_payload = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            o_payload = o_payload | ({$bits(payload_t){i_sel[i]}} & i_payload[i]);
        end
    end

endmodule

//--- hw/wr_grant_sched.sv
`timescale 1ns/1ns

module wr_grant_sched (
    input                                clk,
    input                                resetn,
    input  axi_wr_arb_pkg::master_vec_t  i_aw_req,
    input                                i_b_done,
    input                                i_expired,
    output axi_wr_arb_pkg::master_vec_t  o_grant,
    output logic                         o_grant_start
);

    import axi_wr_arb_pkg::*;

    master_vec_t req_set;    // Masters captured for the current round
    master_vec_t grant;      // One-hot, zero between rounds
    master_vec_t remaining;  // Still to be served after this grant
    logic        grant_end;
    logic        grant_start;

    // Isolate the lowest set bit
    function automatic master_vec_t lowest_bit(input master_vec_t v);
        return v & (~v + master_vec_t'(1));
    endfunction

    ////////////////////
    // Round bookkeeping
    ////////////////////

    assign remaining = req_set & ~grant;
    assign grant_end = (|grant) & (i_b_done | i_expired);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            req_set     <= '0;
            grant       <= '0;
            grant_start <= 1'b0;
        end else begin
            grant_start <= 1'b0;
            if (grant == '0) begin
                // Idle, so a new round may start
                if (|i_aw_req) begin
                    req_set     <= i_aw_req;
                    grant       <= lowest_bit(i_aw_req);
                    grant_start <= 1'b1;
                end
            end else if (grant_end) begin
                // Step to the next higher captured index
                req_set     <= remaining;
                grant       <= lowest_bit(remaining);
                grant_start <= |remaining;  // No pulse when the round is over
            end
        end
    end

    assign o_grant       = grant;
    assign o_grant_start = grant_start;

endmodule

//--- hw/quantum_timer.sv
`timescale 1ns/1ns

module quantum_timer (
    input        clk,
    input        resetn,
    input        i_grant_start,
    input        i_b_done,
    output logic o_expired
);

    import axi_wr_arb_pkg::*;

    logic              running;
    logic [QCNT_W-1:0] cnt;      // Cycles since grant start
    logic              expired;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            running <= 1'b0;
            cnt     <= '0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (i_b_done) begin
                running <= 1'b0;            // Response arrived in time
            end else if (i_grant_start) begin
                running <= 1'b1;
                cnt     <= QCNT_W'(1);
            end else if (running) begin
                // Pulse lands exactly QUANTUM_CYCLES after grant start
                if (cnt == QCNT_W'(QUANTUM_CYCLES - 1)) begin
                    running <= 1'b0;
                    expired <= 1'b1;
                end
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign o_expired = expired;

endmodule

//--- hw/wr_channel_mux.sv
`timescale 1ns/1ns

module wr_channel_mux (
    input                                                              clk,
    input                                                              resetn,
    input  axi_wr_arb_pkg::master_vec_t                                i_grant,
    input                                                              i_grant_start,

    // Master side
    input  axi_wr_arb_pkg::master_vec_t                                i_m_awvalid,
    input  axi_wr_arb_pkg::aw_payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0] i_m_aw,
    output axi_wr_arb_pkg::master_vec_t                                o_m_awready,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_wvalid,
    input  axi_wr_arb_pkg::w_payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0]  i_m_w,
    output axi_wr_arb_pkg::master_vec_t                                o_m_wready,
    output axi_wr_arb_pkg::master_vec_t                                o_m_bvalid,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_bready,

    // Slave side
    output logic                                                       o_s_awvalid,
    output axi_wr_arb_pkg::aw_payload_t                                o_s_aw,
    input                                                              i_s_awready,
    output logic                                                       o_s_wvalid,
    output axi_wr_arb_pkg::w_payload_t                                 o_s_w,
    input                                                              i_s_wready,
    input                                                              i_s_bvalid,
    output logic                                                       o_s_bready,

    output logic                                                       o_b_done
);

    import axi_wr_arb_pkg::*;

    logic aw_done_q, w_done_q;  // Channel already served in this grant
    logic aw_open, w_open;
    logic aw_hs, w_hs;

    ////////////////////
    // Channel guards
    ////////////////////

    // Flags left over from the previous grant do not count in its first cycle
    assign aw_open = ~(aw_done_q & ~i_grant_start);
    assign w_open  = ~(w_done_q & ~i_grant_start);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else if (i_grant_start) begin
            aw_done_q <= aw_hs;  // Handshake may land in the very first cycle
            w_done_q  <= w_hs;
        end else begin
            if (aw_hs) aw_done_q <= 1'b1;
            if (w_hs)  w_done_q  <= 1'b1;
        end
    end

    ////////////////////
    // Routing
    ////////////////////

    // AW channel
    assign o_s_awvalid = (|(i_m_awvalid & i_grant)) & aw_open;
    assign o_m_awready = i_grant & {NUM_MASTERS{i_s_awready & aw_open}};
    assign aw_hs       = o_s_awvalid & i_s_awready;

    // W channel
    assign o_s_wvalid = (|(i_m_wvalid & i_grant)) & w_open;
    assign o_m_wready = i_grant & {NUM_MASTERS{i_s_wready & w_open}};
    assign w_hs       = o_s_wvalid & i_s_wready;

    // B goes back to the granted master only
    assign o_m_bvalid = i_grant & {NUM_MASTERS{i_s_bvalid}};
    assign o_s_bready = |(i_m_bready & i_grant);
    assign o_b_done   = i_s_bvalid & o_s_bready;

    onehot_payload_mux #(
        .payload_t (aw_payload_t)
    ) u_aw_mux (
        .i_sel     (i_grant),
        .i_payload (i_m_aw),
        .o_payload (o_s_aw)
    );

    onehot_payload_mux #(
        .payload_t (w_payload_t)
    ) u_w_mux (
        .i_sel     (i_grant),
        .i_payload (i_m_w),
        .o_payload (o_s_w)
    );

endmodule

//--- hw/axi_lite_wr_arbiter.sv
`timescale 1ns/1ns

module axi_lite_wr_arbiter (
    input                                                              clk,
    input                                                              resetn,

    // Masters
    input  axi_wr_arb_pkg::master_vec_t                                i_m_awvalid,
    input  axi_wr_arb_pkg::aw_payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0] i_m_aw,
    output axi_wr_arb_pkg::master_vec_t                                o_m_awready,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_wvalid,
    input  axi_wr_arb_pkg::w_payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0]  i_m_w,
    output axi_wr_arb_pkg::master_vec_t                                o_m_wready,
    output axi_wr_arb_pkg::master_vec_t                                o_m_bvalid,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_bready,

    // Shared slave
    output logic                                                       o_s_awvalid,
    output axi_wr_arb_pkg::aw_payload_t                                o_s_aw,
    input                                                              i_s_awready,
    output logic                                                       o_s_wvalid,
    output axi_wr_arb_pkg::w_payload_t                                 o_s_w,
    input                                                              i_s_wready,
    input                                                              i_s_bvalid,
    output logic                                                       o_s_bready
);

    import axi_wr_arb_pkg::*;

    master_vec_t grant;        // One-hot owner of the write channels
    logic        grant_start;  // First cycle of each grant
    logic        b_done;
    logic        expired;

    ////////////////////
    // Arbitration
    ////////////////////

    wr_grant_sched u_sched (
        .clk           (clk),
        .resetn        (resetn),
        .i_aw_req      (i_m_awvalid),  // Requests seen on AW only
        .i_b_done      (b_done),
        .i_expired     (expired),
        .o_grant       (grant),
        .o_grant_start (grant_start)
    );

    quantum_timer u_timer (
        .clk           (clk),
        .resetn        (resetn),
        .i_grant_start (grant_start),
        .i_b_done      (b_done),
        .o_expired     (expired)
    );

    ////////////////////
    // Datapath
    ////////////////////

    wr_channel_mux u_chan (
        .clk           (clk),
        .resetn        (resetn),
        .i_grant       (grant),
        .i_grant_start (grant_start),
        .i_m_awvalid   (i_m_awvalid),
        .i_m_aw        (i_m_aw),
        .o_m_awready   (o_m_awready),
        .i_m_wvalid    (i_m_wvalid),
        .i_m_w         (i_m_w),
        .o_m_wready    (o_m_wready),
        .o_m_bvalid    (o_m_bvalid),
        .i_m_bready    (i_m_bready),
        .o_s_awvalid   (o_s_awvalid),
        .o_s_aw        (o_s_aw),
        .i_s_awready   (i_s_awready),
        .o_s_wvalid    (o_s_wvalid),
        .o_s_w         (o_s_w),
        .i_s_wready    (i_s_wready),
        .i_s_bvalid    (i_s_bvalid),
        .o_s_bready    (o_s_bready),
        .o_b_done      (b_done)
    );

endmodule

//--- test/axi_lite_wr_arbiter_assertions.sv
`timescale 1ns/1ns

module axi_lite_wr_arbiter_assertions (
    input                                                              clk,
    input                                                              resetn,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_awvalid,
    input  axi_wr_arb_pkg::aw_payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0] i_m_aw,
    input  axi_wr_arb_pkg::master_vec_t                                o_m_awready,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_wvalid,
    input  axi_wr_arb_pkg::w_payload_t [axi_wr_arb_pkg::NUM_MASTERS-1:0]  i_m_w,
    input  axi_wr_arb_pkg::master_vec_t                                o_m_wready,
    input  axi_wr_arb_pkg::master_vec_t                                o_m_bvalid,
    input  axi_wr_arb_pkg::master_vec_t                                i_m_bready,
    input                                                              o_s_awvalid,
    input  axi_wr_arb_pkg::aw_payload_t                                o_s_aw,
    input                                                              i_s_awready,
    input                                                              o_s_wvalid,
    input  axi_wr_arb_pkg::w_payload_t                                 o_s_w,
    input                                                              i_s_wready,
    input                                                              i_s_bvalid,
    input                                                              o_s_bready
);

    import axi_wr_arb_pkg::*;

    localparam int WAIT_LIMIT = QUANTUM_CYCLES + 8;  // Expiry, regrant and slave delay

    logic              aw_hs, w_hs, all_quiet, waiting, err_seen;
    logic [1:0]        aw_idx;
    aw_payload_t       exp_aw;
    w_payload_t        exp_w;
    master_vec_t       aw_lock, w_lock, served;
    logic [QCNT_W-1:0] aw_age [NUM_MASTERS];
    logic [QCNT_W-1:0] w_age [NUM_MASTERS];
    logic [7:0]        wait_cnt;

    initial err_seen = 1'b0;

    assign aw_hs  = o_s_awvalid & i_s_awready;
    assign w_hs   = o_s_wvalid & i_s_wready;
    assign aw_idx = o_s_aw.addr[1:0];  // Master index carried in the address
    assign all_quiet = !(o_s_awvalid | o_s_wvalid | o_s_bready | (|o_m_awready)
                         | (|o_m_wready) | (|o_m_bvalid));

    // Payload of whichever master the slave ready went to
    always_comb begin
        exp_aw = '0;
        exp_w  = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (o_m_awready[i]) exp_aw = i_m_aw[i];
            if (o_m_wready[i])  exp_w  = i_m_w[i];
        end
    end

    ////////////////////
    // Tracking state
    ////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            aw_lock  <= '0;
            w_lock   <= '0;
            served   <= '0;
            waiting  <= 1'b0;
            wait_cnt <= '0;
            for (int i = 0; i < NUM_MASTERS; i++) begin
                aw_age[i] <= '0;
                w_age[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (aw_hs && o_m_awready[i]) begin
                    aw_lock[i] <= 1'b1;
                    aw_age[i]  <= QCNT_W'(1);
                end else if (o_m_bvalid[i] && i_m_bready[i]) begin
                    aw_lock[i] <= 1'b0;
                end else if (aw_lock[i]) begin
                    if (aw_age[i] == QCNT_W'(QUANTUM_CYCLES)) aw_lock[i] <= 1'b0;
                    aw_age[i] <= aw_age[i] + 1'b1;
                end
                if (w_hs && o_m_wready[i]) begin
                    w_lock[i] <= 1'b1;
                    w_age[i]  <= QCNT_W'(1);
                end else if (o_m_bvalid[i] && i_m_bready[i]) begin
                    w_lock[i] <= 1'b0;
                end else if (w_lock[i]) begin
                    if (w_age[i] == QCNT_W'(QUANTUM_CYCLES)) w_lock[i] <= 1'b0;
                    w_age[i] <= w_age[i] + 1'b1;
                end
            end
            // Served set empties once nothing is in flight or requested
            if (aw_hs) served <= served | master_vec_t'(1 << aw_idx);
            else if (aw_lock == '0 && w_lock == '0 && i_m_awvalid == '0) served <= '0;
            if (aw_hs) begin
                waiting  <= (i_m_awvalid & ~o_m_awready) != '0;
                wait_cnt <= 8'd1;
            end else if (waiting) begin
                wait_cnt <= wait_cnt + 8'd1;
            end
        end
    end

    ////////////////////
    // Properties
    ////////////////////

    a_aw_route: assert property (@(posedge clk) disable iff (!resetn)
        aw_hs |-> $onehot(o_m_awready) && ((o_m_awready & i_m_awvalid) != '0))
        else begin err_seen = 1'b1; $error("AW handshake not owned by one valid master"); end
    a_aw_payload: assert property (@(posedge clk) disable iff (!resetn)
        aw_hs |-> o_s_aw == exp_aw)
        else begin
            err_seen = 1'b1;
            $error("MISMATCH %0t o_s_aw got %h expected %h", $time, o_s_aw, exp_aw);
        end
    a_w_route: assert property (@(posedge clk) disable iff (!resetn)
        w_hs |-> $onehot(o_m_wready) && ((o_m_wready & i_m_wvalid) != '0))
        else begin err_seen = 1'b1; $error("W handshake not owned by one valid master"); end
    a_w_payload: assert property (@(posedge clk) disable iff (!resetn)
        w_hs |-> o_s_w == exp_w)
        else begin
            err_seen = 1'b1;
            $error("MISMATCH %0t o_s_w got %h expected %h", $time, o_s_w, exp_w);
        end
    a_b_excl: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(o_m_bvalid) && (o_m_bvalid == '0 || i_s_bvalid))
        else begin err_seen = 1'b1; $error("B response reached a wrong or extra master"); end
    a_bready: assert property (@(posedge clk) disable iff (!resetn)
        i_s_bvalid |-> o_s_bready == |(i_m_bready & o_m_bvalid))
        else begin
            err_seen = 1'b1;
            $error("MISMATCH %0t o_s_bready got %b expected %b", $time, o_s_bready,
                   |(i_m_bready & o_m_bvalid));
        end
    a_aw_guard: assert property (@(posedge clk) disable iff (!resetn)
        aw_hs |-> (aw_lock & o_m_awready) == '0)
        else begin err_seen = 1'b1; $error("second AW accepted within one grant"); end
    a_w_guard: assert property (@(posedge clk) disable iff (!resetn)
        w_hs |-> (w_lock & o_m_wready) == '0)
        else begin err_seen = 1'b1; $error("second W accepted within one grant"); end
    a_order: assert property (@(posedge clk) disable iff (!resetn)
        aw_hs |-> (served >> aw_idx) == '0)
        else begin err_seen = 1'b1; $error("master %0d served out of round order", aw_idx); end
    a_quantum: assert property (@(posedge clk) disable iff (!resetn)
        !waiting || wait_cnt <= 8'(WAIT_LIMIT))
        else begin err_seen = 1'b1; $error("waiting masters never granted after a stall"); end
    a_reset_hold: assert property (@(posedge clk) !resetn |-> all_quiet)
        else begin err_seen = 1'b1; $error("outputs active during reset"); end
    a_reset_first: assert property (@(posedge clk) $rose(resetn) |-> all_quiet)
        else begin err_seen = 1'b1; $error("outputs active right after reset"); end

endmodule

bind axi_lite_wr_arbiter axi_lite_wr_arbiter_assertions chk0 (.*);

//--- test/tb_axi_lite_wr_arbiter.sv
`timescale 1ns/1ns

module tb_axi_lite_wr_arbiter;

    import axi_wr_arb_pkg::*;

    localparam int CYCLE_LIMIT = 3000;
    localparam int GIVE_UP     = QUANTUM_CYCLES + 8;  // Master stops waiting for B

    logic                          clk;
    logic                          resetn;
    master_vec_t                   m_awvalid, m_awready, m_wvalid, m_wready;
    master_vec_t                   m_bvalid, m_bready;
    aw_payload_t [NUM_MASTERS-1:0] m_aw;
    w_payload_t  [NUM_MASTERS-1:0] m_w;
    logic                          s_awvalid, s_awready, s_wvalid, s_wready;
    logic                          s_bvalid, s_bready;
    aw_payload_t                   s_aw;
    w_payload_t                    s_w;

    logic [15:0] lfsr;
    int          cycles = 0;
    logic        withhold;  // Slave never answers B in this phase

    master_vec_t busy, w_todo, b_wait, aw_hs, w_hs, b_hs;
    master_vec_t resend;  // Valids stay up after their handshake until B
    int          w_dly [NUM_MASTERS];
    int          br_dly [NUM_MASTERS];
    int          age [NUM_MASTERS];
    int          txn [NUM_MASTERS];
    logic        s_aw_got, s_w_got, s_aw_hs, s_w_hs, s_b_hs;
    int          aw_rdy_dly, w_rdy_dly, b_dly;

    axi_lite_wr_arbiter dut0 (
        .clk (clk), .resetn (resetn),
        .i_m_awvalid (m_awvalid), .i_m_aw (m_aw), .o_m_awready (m_awready),
        .i_m_wvalid (m_wvalid), .i_m_w (m_w), .o_m_wready (m_wready),
        .o_m_bvalid (m_bvalid), .i_m_bready (m_bready),
        .o_s_awvalid (s_awvalid), .o_s_aw (s_aw), .i_s_awready (s_awready),
        .o_s_wvalid (s_wvalid), .o_s_w (s_w), .i_s_wready (s_wready),
        .i_s_bvalid (s_bvalid), .o_s_bready (s_bready)
    );

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    ////////////////////
    // Models
    ////////////////////

    task automatic step_models();
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (aw_hs[m]) begin
                m_awvalid[m] = resend[m];
                b_wait[m]    = 1'b1;
                age[m]       = 0;
                draw_bits(1, br_dly[m]);
            end
            if (w_hs[m]) m_wvalid[m] = resend[m];
            if (w_todo[m]) begin
                if (w_dly[m] == 0) begin
                    m_wvalid[m] = 1'b1;
                    w_todo[m]   = 1'b0;
                end else w_dly[m]--;
            end
            if (b_wait[m]) begin
                age[m]++;
                if (br_dly[m] > 0) br_dly[m]--;
                else m_bready[m] = 1'b1;
                if (b_hs[m] || (withhold && age[m] >= GIVE_UP)) begin
                    b_wait[m]    = 1'b0;
                    busy[m]      = 1'b0;
                    w_todo[m]    = 1'b0;
                    m_awvalid[m] = 1'b0;
                    m_wvalid[m]  = 1'b0;
                    m_bready[m]  = 1'b0;
                end
            end
        end
        // Slave side
        if (s_aw_hs) begin
            s_awready = 1'b0;
            s_aw_got  = 1'b1;
            draw_bits(2, aw_rdy_dly);
        end else if (s_awvalid && !s_awready) begin
            if (aw_rdy_dly == 0) s_awready = 1'b1;
            else aw_rdy_dly--;
        end
        if (s_w_hs) begin
            s_wready = 1'b0;
            s_w_got  = 1'b1;
            draw_bits(2, w_rdy_dly);
        end else if (s_wvalid && !s_wready) begin
            if (w_rdy_dly == 0) s_wready = 1'b1;
            else w_rdy_dly--;
        end
        if (s_b_hs) begin
            s_bvalid = 1'b0;
            s_aw_got = 1'b0;
            s_w_got  = 1'b0;
            draw_bits(1, b_dly);
        end else if (s_aw_got && s_w_got && !s_bvalid) begin
            if (withhold) begin
                s_aw_got = 1'b0;
                s_w_got  = 1'b0;
            end else if (b_dly == 0) s_bvalid = 1'b1;
            else b_dly--;
        end
    endtask

    // All chosen masters request in the same cycle, so one round holds them all
    task automatic start_batch();
        int pick;
        int coin;
        draw_bits(3, pick);
        if (pick == 0) pick = 7;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (pick[m]) begin
                busy[m]      = 1'b1;
                w_todo[m]    = 1'b1;
                draw_bits(2, w_dly[m]);
                draw_bits(1, coin);
                resend[m]    = coin[0] & ~withhold;  // Channel guards hold these off
                txn[m]++;
                m_aw[m].addr = ADDR_W'((txn[m] << 2) | m);
                m_aw[m].prot = PROT_W'(m);
                m_w[m].data  = DATA_W'((txn[m] << 8) | (m << 4) | 4'hd);
                m_w[m].strb  = '1;
                m_awvalid[m] = 1'b1;
            end
        end
    endtask

    task automatic next_cycle(input logic launch);
        @(negedge clk);
        step_models();
        if (launch) start_batch();
        #1;
        aw_hs   = m_awvalid & m_awready;
        w_hs    = m_wvalid & m_wready;
        b_hs    = m_bvalid & m_bready;
        s_aw_hs = s_awvalid & s_awready;
        s_w_hs  = s_wvalid & s_wready;
        s_b_hs  = s_bvalid & s_bready;
    endtask

    task automatic run_batches(input int n, input logic hold);
        withhold = hold;
        for (int b = 0; b < n; b++) begin
            next_cycle(1'b1);
            while (busy != '0) next_cycle(1'b0);
            repeat (2) next_cycle(1'b0);
        end
    endtask

    ////////////////////
    // Run control
    ////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("tests failed");
            $fatal(1, "Run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(negedge clk) begin
        if (dut0.chk0.err_seen === 1'b1) begin
            $display("tests failed");
            $fatal(1, "A bound assertion on the arbiter failed");
        end
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        lfsr = 16'd4;
        withhold = 1'b0;
        {m_awvalid, m_wvalid, m_bready} = '1;  // Held active through reset
        {busy, w_todo, b_wait, resend} = '0;
        {aw_hs, w_hs, b_hs} = '0;
        m_aw = '0;
        m_w = '0;
        {s_awready, s_wready, s_bvalid} = '1;
        {s_aw_got, s_w_got} = '0;
        {s_aw_hs, s_w_hs, s_b_hs} = '0;
        aw_rdy_dly = 1;
        w_rdy_dly = 2;
        b_dly = 0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            w_dly[m] = 0;
            br_dly[m] = 0;
            age[m] = 0;
            txn[m] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        {m_awvalid, m_wvalid, m_bready} = '0;
        {s_awready, s_wready, s_bvalid} = '0;
        run_batches(30, 1'b0);
        run_batches(6, 1'b1);   // Quantum phase
        run_batches(6, 1'b0);
        if (dut0.chk0.err_seen === 1'b1) begin
            $display("tests failed");
            $fatal(1, "A bound assertion on the arbiter failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- axi_lite_wr_arbiter.f
hw/axi_wr_arb_pkg.sv
hw/onehot_payload_mux.sv
hw/wr_grant_sched.sv
hw/quantum_timer.sv
hw/wr_channel_mux.sv
hw/axi_lite_wr_arbiter.sv
test/axi_lite_wr_arbiter_assertions.sv
test/tb_axi_lite_wr_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f axi_lite_wr_arbiter.f \
    --top-module tb_axi_lite_wr_arbiter \
    -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi
